//--- include/pov_config.svh
`ifndef POV_CONFIG_SVH
`define POV_CONFIG_SVH

// Geometry and sizing of the rotating display

// Number of angular slices in each half turn
// A full turn therefore has twice as many columns
`define POV_SLICES_PER_HALF 128

// Width of the counter that measures one half turn in clock cycles
// 32 bits leave plenty of room even for a very slow rotor
`define POV_PERIOD_WIDTH 32

// Number of LEDs stacked along the blade, one bit per LED in a column
`define POV_LED_COUNT 8

`endif

//--- source/rotor_pkg.sv
`include "pov_config.svh"

package rotor_pkg;

    // Which Hall sensor produced the latest top
    // half_a follows hall_1 and half_b follows hall_2
    typedef enum logic {
        half_a,
        half_b
    } half_turn_t;

    // Position event from the sensor FSM
    // The top flag is high for a single cycle per sensor pass
    typedef struct packed {
        logic       top;
        half_turn_t half;
    } rotor_event_t;

    // Slice number over the whole turn, 0 to 255
    typedef logic [$clog2(2 * `POV_SLICES_PER_HALF)-1:0] slice_index_t;

    // Current angular slice with a one-cycle strobe at the start of each slice
    typedef struct packed {
        logic         strobe;
        slice_index_t index;
    } slice_pos_t;

endpackage

//--- source/display_pkg.sv
`include "pov_config.svh"

package display_pkg;

    // One image column as shown on the blade
    // The MSB drives the outermost LED
    typedef logic [`POV_LED_COUNT-1:0] led_column_t;

    // Column address inside the image, one column per slice of a full turn
    typedef logic [$clog2(2 * `POV_SLICES_PER_HALF)-1:0] column_addr_t;

    // Host write into the image memory
    // Only the cycle where en is high carries a write
    typedef struct packed {
        logic         en;
        column_addr_t addr;
        led_column_t  data;
    } column_write_t;

endpackage

//--- source/hall_sensor_fsm.sv
`timescale 1ns/100ps

module hall_sensor_fsm (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    hall_1,
    input  logic                    hall_2,
    output rotor_pkg::rotor_event_t rotor_event
);

    import rotor_pkg::*;

    // Armed waits for a magnet, guarded waits until both sensors are released
    typedef enum logic {
        armed,
        guarded
    } guard_state_t;

    // Synchronizer chains, bit 1 is the stable output
    logic [1:0] sync_1;
    logic [1:0] sync_2;
    logic       hall_1_s;
    logic       hall_2_s;
    guard_state_t state;

    // The sensors are idle high, so the chains start high to avoid a false top
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            sync_1 <= 2'b11;
            sync_2 <= 2'b11;
        end else begin
            sync_1 <= {sync_1[0], hall_1};
            sync_2 <= {sync_2[0], hall_2};
        end
    end

    assign hall_1_s = sync_1[1];
    assign hall_2_s = sync_2[1];

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state            <= armed;
            rotor_event.top  <= 1'b0;
            rotor_event.half <= half_a;
        end else begin
            rotor_event.top <= 1'b0;
            case (state)
                armed: begin
                    // First low level seen while armed gives exactly one top
                    if (!hall_1_s || !hall_2_s) begin
                        rotor_event.top <= 1'b1;
                        state           <= guarded;
                        // hall_1 takes priority when both are low together
                        if (!hall_1_s) begin
                            rotor_event.half <= half_a;
                        end else begin
                            rotor_event.half <= half_b;
                        end
                    end
                end
                guarded: begin
                    // Rearm only once the magnet has left both sensors
                    if (hall_1_s && hall_2_s) begin
                        state <= armed;
                    end
                end
                default: begin
                    state <= armed;
                end
            endcase
        end
    end

endmodule

//--- source/slice_timer.sv
`include "pov_config.svh"
`timescale 1ns/100ps

module slice_timer (
    input  logic                    clk,
    input  logic                    nrst,
    input  rotor_pkg::rotor_event_t rotor_event,
    output rotor_pkg::slice_pos_t   slice
);

    import rotor_pkg::*;

    // Dividing by the slice count is a plain right shift
    localparam int SLICE_SHIFT    = $clog2(`POV_SLICES_PER_HALF);
    localparam int INTERVAL_WIDTH = `POV_PERIOD_WIDTH - SLICE_SHIFT;

    // Cycles since the last top
    logic [`POV_PERIOD_WIDTH-1:0] period_cnt;
    // High once a top has been seen, so the next top closes a real measurement
    logic                         period_valid;
    // Cycles per slice, taken from the previous half turn
    logic [INTERVAL_WIDTH-1:0]    interval;
    // Cycles elapsed inside the current slice
    logic [INTERVAL_WIDTH-1:0]    cycle_cnt;
    // Slice number inside the current half turn
    logic [SLICE_SHIFT-1:0]       half_cnt;
    logic                         strobe;

    // Half-turn period measurement
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            period_cnt   <= '0;
            period_valid <= 1'b0;
            interval     <= '0;
        end else if (rotor_event.top) begin
            // The count since reset is meaningless, so the interval stays 0
            // until one full half turn lies between two tops
            if (period_valid) begin
                interval <= INTERVAL_WIDTH'(period_cnt >> SLICE_SHIFT);
            end
            period_valid <= 1'b1;
            period_cnt   <= 1;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    // Slice strobe generation
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            strobe    <= 1'b0;
            cycle_cnt <= '0;
            half_cnt  <= '0;
        end else begin
            strobe <= 1'b0;
            if (rotor_event.top) begin
                // Every top resynchronizes to slice 0 of the new half
                strobe    <= 1'b1;
                cycle_cnt <= '0;
                half_cnt  <= '0;
            end else if (interval != '0 && half_cnt != '1
                         && cycle_cnt == interval - 1'b1) begin
                // Stop after the last slice of the half and wait for the next top
                strobe    <= 1'b1;
                cycle_cnt <= '0;
                half_cnt  <= half_cnt + 1'b1;
            end else begin
                cycle_cnt <= cycle_cnt + 1'b1;
            end
        end
    end

    // The second half turn maps onto slices 128 to 255
    always_comb begin
        slice.strobe = strobe;
        slice.index  = {rotor_event.half == half_b, half_cnt};
    end

endmodule

//--- source/column_buffer.sv
`include "pov_config.svh"
`timescale 1ns/100ps

module column_buffer (
    input  logic                       clk,
    input  logic                       nrst,
    input  display_pkg::column_write_t wr,
    input  rotor_pkg::slice_pos_t      slice,
    output display_pkg::led_column_t   column,
    output logic                       col_valid
);

    import rotor_pkg::*;
    import display_pkg::*;

    // One column for every slice of a full turn
    localparam int DEPTH = 2 * `POV_SLICES_PER_HALF;

    // Image memory, filled by the host before the rotor spins up
    led_column_t  mem [DEPTH];
    slice_index_t rd_addr;

    assign rd_addr = slice.index;

    // Host write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Read port, sampled once per slice
    // A write to the same address in this cycle is seen on the next read
    always_ff @(posedge clk) begin
        if (slice.strobe) begin
            column <= mem[rd_addr];
        end
    end

    // The valid pulse lines up with the registered read data
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            col_valid <= 1'b0;
        end else begin
            col_valid <= slice.strobe;
        end
    end

endmodule

//--- source/led_shift_out.sv
`include "pov_config.svh"
`timescale 1ns/100ps

module led_shift_out (
    input  logic                     clk,
    input  logic                     nrst,
    input  display_pkg::led_column_t column,
    input  logic                     col_valid,
    output logic                     led_sclk,
    output logic                     led_sdata,
    output logic                     led_latch
);

    import display_pkg::*;

    localparam int BIT_WIDTH = $clog2(`POV_LED_COUNT);
    localparam logic [BIT_WIDTH-1:0] LAST_BIT = BIT_WIDTH'(`POV_LED_COUNT - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_shift,
        st_latch
    } shift_state_t;

    shift_state_t           state;
    // Column being sent, MSB goes out first
    led_column_t            shreg;
    // Column that arrived while the driver was busy
    led_column_t            pending;
    logic                   pending_valid;
    logic [BIT_WIDTH-1:0]   bit_cnt;
    // Low half of a bit period sets up data, high half clocks it
    logic                   phase;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state         <= st_idle;
            bit_cnt       <= '0;
            phase         <= 1'b0;
            pending_valid <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (col_valid) begin
                        state   <= st_shift;
                        bit_cnt <= '0;
                        phase   <= 1'b0;
                    end
                end
                st_shift: begin
                    phase <= ~phase;
                    if (phase) begin
                        if (bit_cnt == LAST_BIT) begin
                            state <= st_latch;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    if (col_valid) begin
                        pending_valid <= 1'b1;
                    end
                end
                st_latch: begin
                    // A waiting column goes out right after the latch pulse
                    bit_cnt       <= '0;
                    phase         <= 1'b0;
                    pending_valid <= 1'b0;
                    if (col_valid || pending_valid) begin
                        state <= st_shift;
                    end else begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Shift and pending data paths
    always_ff @(posedge clk) begin
        case (state)
            st_idle: begin
                if (col_valid) begin
                    shreg <= column;
                end
            end
            st_shift: begin
                if (phase) begin
                    shreg <= shreg << 1;
                end
                // A newer column simply replaces an older waiting one
                if (col_valid) begin
                    pending <= column;
                end
            end
            st_latch: begin
                // Data arriving in the latch cycle is newer than the pending copy
                if (col_valid) begin
                    shreg <= column;
                end else if (pending_valid) begin
                    shreg <= pending;
                end
            end
            default: begin
                shreg <= shreg;
            end
        endcase
    end

    assign led_sclk  = (state == st_shift) && phase;
    assign led_sdata = (state == st_shift) && shreg[`POV_LED_COUNT-1];
    assign led_latch = (state == st_latch);

endmodule

//--- source/pov_display_top.sv
`timescale 1ns/100ps

module pov_display_top (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       hall_1,
    input  logic                       hall_2,
    input  display_pkg::column_write_t col_write,
    output logic                       led_sclk,
    output logic                       led_sdata,
    output logic                       led_latch,
    output rotor_pkg::slice_pos_t      slice
);

    import rotor_pkg::*;
    import display_pkg::*;

    // Top events and the current half from the sensor FSM
    rotor_event_t rotor_event;
    // Registered column read for the current slice
    led_column_t  column;
    logic         col_valid;

    // Hall sensors to one-cycle top events
    hall_sensor_fsm u_hall_sensor_fsm (
        .clk         (clk),
        .nrst        (nrst),
        .hall_1      (hall_1),
        .hall_2      (hall_2),
        .rotor_event (rotor_event)
    );

    // Tops to slice strobes and the slice index over the turn
    slice_timer u_slice_timer (
        .clk         (clk),
        .nrst        (nrst),
        .rotor_event (rotor_event),
        .slice       (slice)
    );

    // Image memory, host writes on one side and slice reads on the other
    column_buffer u_column_buffer (
        .clk       (clk),
        .nrst      (nrst),
        .wr        (col_write),
        .slice     (slice),
        .column    (column),
        .col_valid (col_valid)
    );

    // Serial link to the external LED driver
    led_shift_out u_led_shift_out (
        .clk       (clk),
        .nrst      (nrst),
        .column    (column),
        .col_valid (col_valid),
        .led_sclk  (led_sclk),
        .led_sdata (led_sdata),
        .led_latch (led_latch)
    );

endmodule

//--- verification/pov_display_tb.sv
`include "pov_config.svh"
`timescale 1ns/100ps

module pov_display_tb;

    import rotor_pkg::*;
    import display_pkg::*;

    localparam int HALF = `POV_SLICES_PER_HALF;
    localparam int LEDS = `POV_LED_COUNT;
    // Column that the host rewrites while the rotor spins
    localparam int REWRITE_ADDR = 5;

    // One half turn of the rotor with the strobe count it must produce
    typedef struct {
        int sensor;
        int period;
        int pulse;
        bit glitch;
        bit rewrite;
        int min_strobes;
        int max_strobes;
    } row_t;

    // The first half turn has no measured period, so only its top strobe appears
    // Row 2 holds the sensor low for a long time, row 3 pulses the other sensor
    // while the first one is still low, row 7 speeds up and stops after 64 slices
    row_t rows [8] = '{
        '{1, 4096,    8, 1'b0, 1'b0,   1,   1},
        '{2, 4096,    8, 1'b0, 1'b0, 128, 129},
        '{1, 4096, 2000, 1'b0, 1'b0, 128, 129},
        '{2, 4096,  600, 1'b1, 1'b0, 128, 129},
        '{1, 8192,   16, 1'b0, 1'b1, 128, 129},
        '{2, 8192,   16, 1'b0, 1'b0, 128, 129},
        '{1, 8192,   16, 1'b0, 1'b0, 128, 129},
        '{2, 4096,   16, 1'b0, 1'b0,  64,  64}
    };

    logic          clk;
    logic          nrst;
    logic          hall_1;
    logic          hall_2;
    column_write_t col_write;
    logic          led_sclk;
    logic          led_sdata;
    logic          led_latch;
    slice_pos_t    slice;

    // Model of the image memory that follows every host write
    led_column_t  image [2 * HALF];
    // Expected columns in strobe order that each latch removes again
    slice_index_t idx_q [$];
    led_column_t  col_q [$];
    slice_index_t last_index = '0;
    slice_index_t next_index;
    slice_index_t got_index;
    led_column_t  rx = '0;
    led_column_t  rewrite_data = '0;
    int           rx_bits = 0;
    int           exp_base = 0;
    int           strobe_cnt = 0;
    int           top_cnt = 0;
    int           strobes_total = 0;
    int           cols_checked = 0;
    int           rewrite_seen = 0;
    int           errors = 0;
    bit           rewrite_done = 1'b0;

    pov_display_top u_pov_display_top (
        .clk       (clk),
        .nrst      (nrst),
        .hall_1    (hall_1),
        .hall_2    (hall_2),
        .col_write (col_write),
        .led_sclk  (led_sclk),
        .led_sdata (led_sdata),
        .led_latch (led_latch),
        .slice     (slice)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
    endtask

    task automatic log_failure(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // All stimulus changes 1 ns after the rising edge
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic write_column(input slice_index_t addr, input led_column_t data);
        col_write.en   = 1'b1;
        col_write.addr = addr;
        col_write.data = data;
        wait_cycles(1);
        col_write.en = 1'b0;
    endtask

    task automatic drive_sensor(input int sensor, input logic level);
        if (sensor == 1) begin
            hall_1 = level;
        end else begin
            hall_2 = level;
        end
    endtask

    // Pulls one sensor low for the pulse and keeps the row exactly one period long
    task automatic run_row(input row_t r);
        int rest;
        exp_base   = (r.sensor == 2) ? HALF : 0;
        strobe_cnt = 0;
        top_cnt    = 0;
        drive_sensor(r.sensor, 1'b0);
        if (r.glitch) begin
            // The other sensor drops while the guard is closed and must be ignored
            wait_cycles(r.pulse / 4);
            drive_sensor(3 - r.sensor, 1'b0);
            wait_cycles(r.pulse / 4);
            drive_sensor(3 - r.sensor, 1'b1);
            wait_cycles(r.pulse - 2 * (r.pulse / 4));
        end else begin
            wait_cycles(r.pulse);
        end
        drive_sensor(r.sensor, 1'b1);
        rest = r.period - r.pulse;
        if (r.rewrite) begin
            rewrite_data = ~image[REWRITE_ADDR];
            write_column(slice_index_t'(REWRITE_ADDR), rewrite_data);
            rewrite_done = 1'b1;
            rest = rest - 1;
        end
        wait_cycles(rest);
        // Every strobe of this half turn has arrived before the next top
        if (top_cnt != 1) begin
            report_mismatch("top strobe count", top_cnt, 1);
        end
        if (strobe_cnt < r.min_strobes || strobe_cnt > r.max_strobes) begin
            report_mismatch("slice.strobe count", strobe_cnt, r.min_strobes);
        end
    endtask

    task automatic drain_output();
        int n;
        n = 0;
        while (idx_q.size() != 0 && n < 200) begin
            wait_cycles(1);
            n++;
        end
        if (idx_q.size() != 0) begin
            log_failure("timeout while waiting for the last columns to be latched");
        end
    endtask

    // The strobe monitor, the image model and the serial decoder all sample mid cycle
    always @(negedge clk) begin
        if (nrst && slice.strobe) begin
            strobe_cnt++;
            strobes_total++;
            idx_q.push_back(slice.index);
            col_q.push_back(image[slice.index]);
            next_index = last_index + 1'b1;
            if (slice.index % HALF == 0) begin
                top_cnt++;
                if (int'(slice.index) != exp_base) begin
                    report_mismatch("slice.index", 32'(slice.index), exp_base);
                end
            end else if (slice.index != next_index || int'(slice.index) < exp_base
                         || int'(slice.index) >= exp_base + HALF) begin
                report_mismatch("slice.index", 32'(slice.index), 32'(next_index));
            end
            last_index = slice.index;
        end
        // A read in the same cycle as a write still returns the old column
        if (col_write.en) begin
            image[col_write.addr] = col_write.data;
        end
        if (led_sclk) begin
            rx = {rx[LEDS-2:0], led_sdata};
            rx_bits++;
        end
        if (led_latch) begin
            if (rx_bits != LEDS) begin
                report_mismatch("led_sclk pulses", rx_bits, LEDS);
            end
            if (idx_q.size() == 0) begin
                log_failure("led_latch pulsed without a preceding slice strobe");
            end else begin
                got_index = idx_q.pop_front();
                if (rx != col_q[0]) begin
                    report_mismatch($sformatf("led_sdata column %0d", got_index),
                                    32'(rx), 32'(col_q[0]));
                end
                void'(col_q.pop_front());
                cols_checked++;
                if (rewrite_done && got_index == REWRITE_ADDR) begin
                    rewrite_seen++;
                    if (rx != rewrite_data) begin
                        report_mismatch("led_sdata rewritten column", 32'(rx),
                                        32'(rewrite_data));
                    end
                end
            end
            rx_bits = 0;
        end
    end

    initial begin
        int seed;
        nrst      = 1'b0;
        hall_1    = 1'b1;
        hall_2    = 1'b1;
        col_write = '0;
        seed = $urandom(32'h9de5);
        repeat (4) @(posedge clk);
        #1;
        nrst = 1'b1;
        // Image fill while the rotor stands still and every output is quiet
        for (int a = 0; a < 2 * HALF; a++) begin
            write_column(slice_index_t'(a), led_column_t'($urandom));
            if (led_sclk !== 1'b0) begin
                report_mismatch("led_sclk", 32'(led_sclk), 0);
            end
            if (led_latch !== 1'b0) begin
                report_mismatch("led_latch", 32'(led_latch), 0);
            end
            if (slice.strobe !== 1'b0) begin
                report_mismatch("slice.strobe", 32'(slice.strobe), 0);
            end
        end
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        drain_output();
        if (rewrite_seen == 0) begin
            log_failure("no column was latched for the address rewritten during rotation");
        end
        if (cols_checked == 0) begin
            log_failure("no column was latched at all");
        end
        $display("errors %0d, strobes %0d, columns checked %0d",
                 errors, strobes_total, cols_checked);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+include
source/rotor_pkg.sv
source/display_pkg.sv
source/hall_sensor_fsm.sv
source/slice_timer.sv
source/column_buffer.sv
source/led_shift_out.sv
source/pov_display_top.sv
verification/pov_display_tb.sv

//--- Makefile
# Verilator flow for the POV display
# Any variable below can be overridden on the command line

VERILATOR  ?= verilator
FILELIST   ?= all.f
TB_TOP     ?= pov_display_tb
RTL_TOP    ?= pov_display_top
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing
PASS_TEXT  ?= === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
